/* bp_cfg_pkg.sv */
package bp_cfg_pkg;

    localparam int SLOT_NUM   = 2;    // Conditional slots per prediction
    localparam int GHIST_SIZE = 128;  // Circular history depth
    localparam int GHIST_W    = 7;
    localparam int TAGE_BANK  = 4;

    // Fold widths
    localparam int IDX_W  = 8;
    localparam int TAG1_W = 8;
    localparam int TAG2_W = 7;

    localparam int TAG_W = 8;         // Table tag width
    localparam int PC_W  = 32;

    // Bank 0 has the shortest history
    localparam logic [TAGE_BANK-1:0][8:0] DEF_HIST_LEN = {
        9'd119,
        9'd32,
        9'd13,
        9'd8
    };

endpackage

/* bp_history.f */
bp_cfg_pkg.sv
bp_types_pkg.sv
fold_history.sv
history_control.sv
tage_index_hash.sv
bp_history_top.sv
tb_clock_gen.sv
tb_bp_history.sv

/* bp_history_top.sv */
`timescale 1ns/1ns

module bp_history_top #(
    parameter logic [bp_cfg_pkg::TAGE_BANK-1:0][8:0] HIST_LEN = bp_cfg_pkg::DEF_HIST_LEN
) (
    input  logic                        clk,
    input  logic                        rst,
    input  bp_types_pkg::pred_event_t   pred,
    input  logic                        s2_redirect,
    input  logic                        squash,
    input  bp_types_pkg::squash_event_t sq_info,
    input  bp_types_pkg::lookup_req_t   lookup,
    output bp_types_pkg::hist_ckpt_t    history,
    output bp_types_pkg::lookup_resp_t  resp
);

    // History update stage
    history_control #(
        .HIST_LEN (HIST_LEN)
    ) u_history_control (
        .clk         (clk),
        .rst         (rst),
        .pred        (pred),
        .s2_redirect (s2_redirect),
        .squash      (squash),
        .sq_info     (sq_info),
        .history     (history)
    );

    // Hash stage reads the registered folds
    tage_index_hash #(
        .HIST_LEN (HIST_LEN)
    ) u_tage_index_hash (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup),
        .fold   (history.fold),
        .resp   (resp)
    );

endmodule

/* bp_types_pkg.sv */
package bp_types_pkg;

    typedef enum logic [1:0] {
        HIST_HOLD,
        HIST_PREDICT,
        HIST_REDIRECT,
        HIST_SQUASH
    } hist_src_e;

    // One entry per bank in each field
    typedef struct packed {
        logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::IDX_W-1:0]  idx;
        logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::TAG1_W-1:0] tag1;
        logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::TAG2_W-1:0] tag2;
    } tage_fold_t;

    typedef struct packed {
        logic [bp_cfg_pkg::GHIST_W-1:0] ghist_idx;  // Next write slot
        tage_fold_t                     fold;
    } hist_ckpt_t;

    typedef struct packed {
        logic       en;
        logic [1:0] cond_num;  // 0 to SLOT_NUM
        logic       taken;     // Outcome of the last conditional
        hist_ckpt_t redirect;
    } pred_event_t;

    typedef struct packed {
        logic [1:0] cond_num;
        logic       taken;
        hist_ckpt_t ckpt;
    } squash_event_t;

    typedef struct packed {
        logic                        en;
        logic [bp_cfg_pkg::PC_W-1:0] pc;
    } lookup_req_t;

    typedef struct packed {
        logic                                                    valid;
        logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::IDX_W-1:0] idx;
        logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::TAG_W-1:0] tag;
    } lookup_resp_t;

endpackage

/* fold_history.sv */
`timescale 1ns/1ns

module fold_history #(
    parameter int L = 8,
    parameter int W = 8
) (
    input  logic [W-1:0] origin,
    input  logic [1:0]   n,
    input  logic         dir,
    input  logic [1:0]   old_bits,  // [0] leaves on the first append
    output logic [W-1:0] fold_out
);

    localparam int OUT_POS = L % W;  // Slot the expiring bit rotates into

    // One appended bit: rotate, add the new bit, cancel the expiring one
    function automatic logic [W-1:0] shift_in(
        input logic [W-1:0] f,
        input logic         d,
        input logic         old
    );
        logic [W-1:0] r;
        r = {f[W-2:0], f[W-1]};
        r[0] = r[0] ^ d;
        r[OUT_POS] = r[OUT_POS] ^ old;
        return r;
    endfunction

    always_comb begin
        case (n)
            2'd1:    fold_out = shift_in(origin, dir, old_bits[0]);
            2'd2:    fold_out = shift_in(shift_in(origin, 1'b0, old_bits[0]), dir, old_bits[1]);
            default: fold_out = origin;
        endcase
    end

endmodule

/* history_control.sv */
`timescale 1ns/1ns

module history_control #(
    parameter logic [bp_cfg_pkg::TAGE_BANK-1:0][8:0] HIST_LEN = bp_cfg_pkg::DEF_HIST_LEN
) (
    input  logic                        clk,
    input  logic                        rst,
    input  bp_types_pkg::pred_event_t   pred,
    input  logic                        s2_redirect,
    input  logic                        squash,
    input  bp_types_pkg::squash_event_t sq_info,
    output bp_types_pkg::hist_ckpt_t    history
);

    logic [bp_cfg_pkg::GHIST_SIZE-1:0] ghist;
    bp_types_pkg::hist_ckpt_t          state_q;
    bp_types_pkg::hist_ckpt_t          base;
    bp_types_pkg::hist_ckpt_t          state_d;
    bp_types_pkg::tage_fold_t          fold_new;
    bp_types_pkg::hist_src_e           src;
    logic [1:0]                        n;
    logic                              taken;
    logic [bp_cfg_pkg::GHIST_W-1:0]    wr_idx_hi;

    // Squash wins over redirect, redirect over a plain prediction
    always_comb begin
        if (squash) begin
            src = bp_types_pkg::HIST_SQUASH;
        end else if (s2_redirect) begin
            src = bp_types_pkg::HIST_REDIRECT;
        end else if (pred.en) begin
            src = bp_types_pkg::HIST_PREDICT;
        end else begin
            src = bp_types_pkg::HIST_HOLD;
        end
    end

    always_comb begin
        base = state_q;  // Live state unless restored
        n = 2'd0;
        taken = 1'b0;
        case (src)
            bp_types_pkg::HIST_SQUASH: begin
                base = sq_info.ckpt;
                n = sq_info.cond_num;
                taken = sq_info.taken;
            end
            bp_types_pkg::HIST_REDIRECT: begin
                base = pred.redirect;
                n = pred.cond_num;
                taken = pred.taken;
            end
            bp_types_pkg::HIST_PREDICT: begin
                n = pred.cond_num;
                taken = pred.taken;
            end
            default: begin
            end
        endcase
    end

    for (genvar b = 0; b < bp_cfg_pkg::TAGE_BANK; b++) begin : g_bank
        logic [bp_cfg_pkg::GHIST_W-1:0] old_ptr;
        logic [1:0]                     old_bits;

        // Bit L places back drops out of the window first
        assign old_ptr = base.ghist_idx - HIST_LEN[b][bp_cfg_pkg::GHIST_W-1:0];
        assign old_bits = {ghist[old_ptr + 1'b1], ghist[old_ptr]};

        fold_history #(.L(HIST_LEN[b]), .W(bp_cfg_pkg::IDX_W)) u_fold_idx (
            .origin   (base.fold.idx[b]),
            .n        (n),
            .dir      (taken),
            .old_bits (old_bits),
            .fold_out (fold_new.idx[b])
        );

        fold_history #(.L(HIST_LEN[b]), .W(bp_cfg_pkg::TAG1_W)) u_fold_tag1 (
            .origin   (base.fold.tag1[b]),
            .n        (n),
            .dir      (taken),
            .old_bits (old_bits),
            .fold_out (fold_new.tag1[b])
        );

        fold_history #(.L(HIST_LEN[b]), .W(bp_cfg_pkg::TAG2_W)) u_fold_tag2 (
            .origin   (base.fold.tag2[b]),
            .n        (n),
            .dir      (taken),
            .old_bits (old_bits),
            .fold_out (fold_new.tag2[b])
        );
    end

    assign wr_idx_hi = base.ghist_idx + 1'b1;
    assign state_d.ghist_idx = base.ghist_idx + bp_cfg_pkg::GHIST_W'(n);
    assign state_d.fold = fold_new;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            state_q <= '0;
        end else begin
            state_q <= state_d;
            case (n)
                2'd1: ghist[base.ghist_idx] <= taken;
                2'd2: begin
                    ghist[base.ghist_idx] <= 1'b0;  // Only the last outcome can be taken
                    ghist[wr_idx_hi] <= taken;
                end
                default: begin
                end
            endcase
        end
    end

    assign history = state_q;

    a_cond_num_range: assert property (
        @(posedge clk) disable iff (rst)
        src != bp_types_pkg::HIST_HOLD |-> n != 2'd3
    );

    // An empty event leaves the position and folds on its base checkpoint
    a_empty_predict_holds: assert property (
        @(posedge clk) disable iff (rst)
        src == bp_types_pkg::HIST_PREDICT && n == 2'd0 |=> $stable(history)
    );

    a_empty_squash_restores: assert property (
        @(posedge clk) disable iff (rst)
        src == bp_types_pkg::HIST_SQUASH && n == 2'd0 |=> history == $past(sq_info.ckpt)
    );

endmodule

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_bp_history -o tb_bp_history_sim \
    -f bp_history.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_bp_history_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

/* tage_index_hash.sv */
`timescale 1ns/1ns

module tage_index_hash #(
    parameter logic [bp_cfg_pkg::TAGE_BANK-1:0][8:0] HIST_LEN = bp_cfg_pkg::DEF_HIST_LEN
) (
    input  logic                       clk,
    input  logic                       rst,
    input  bp_types_pkg::lookup_req_t  lookup,
    input  bp_types_pkg::tage_fold_t   fold,
    output bp_types_pkg::lookup_resp_t resp
);

    logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::IDX_W-1:0] idx_d;
    logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::TAG_W-1:0] tag_d;
    logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::IDX_W-1:0] idx_q;
    logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::TAG_W-1:0] tag_q;
    logic                                                    valid_q;

    for (genvar b = 0; b < bp_cfg_pkg::TAGE_BANK; b++) begin : g_bank
        localparam bit USE_HIST = HIST_LEN[b] != 9'd0;  // Zero length means PC only

        logic [bp_cfg_pkg::PC_W-1:0]  pc_shift;
        logic [bp_cfg_pkg::IDX_W-1:0] idx_fold;
        logic [bp_cfg_pkg::TAG_W-1:0] tag_fold;

        assign pc_shift = lookup.pc >> (2 + b);  // Spreads banks apart
        assign idx_fold = USE_HIST ? fold.idx[b] : '0;
        assign tag_fold = USE_HIST ? (fold.tag1[b] ^ {fold.tag2[b], 1'b0}) : '0;

        assign idx_d[b] = lookup.pc[bp_cfg_pkg::IDX_W+1:2] ^ idx_fold
                        ^ pc_shift[bp_cfg_pkg::IDX_W-1:0];
        assign tag_d[b] = lookup.pc[bp_cfg_pkg::TAG_W+1:2] ^ tag_fold;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lookup.en;
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= idx_d;
        tag_q <= tag_d;
    end

    always_comb begin
        resp.valid = valid_q;
        resp.idx = idx_q;
        resp.tag = tag_q;
    end

    a_valid_follows_en: assert property (
        @(posedge clk) disable iff (rst)
        resp.valid == $past(lookup.en)
    );

endmodule

/* tb_bp_history.sv */
`timescale 1ns/1ns

module tb_bp_history;

    localparam int CLK_PERIOD   = 40;
    localparam int N_PRED       = 300;  // Enough bits to wrap the history twice
    localparam int N_ROUND      = 40;   // Five events per restore round
    localparam int N_LOOKUP     = 64;
    localparam int TOTAL_EVENTS = 4 + N_PRED + 2 * N_ROUND * 5 + N_LOOKUP + 1;

    logic                        clk;
    logic                        rst;
    bp_types_pkg::pred_event_t   pred;
    logic                        s2_redirect;
    logic                        squash;
    bp_types_pkg::squash_event_t sq_info;
    bp_types_pkg::lookup_req_t   lookup;
    bp_types_pkg::hist_ckpt_t    history;
    bp_types_pkg::lookup_resp_t  resp;

    logic [bp_cfg_pkg::GHIST_SIZE-1:0] m_hist;  // Mirror of the circular history
    int                                m_pos;
    bp_types_pkg::hist_ckpt_t          path_q[$];  // Checkpoints on the live path

    // Expected values and the falling edge where each becomes valid
    time                        ck_due_q[$];
    bp_types_pkg::hist_ckpt_t   ck_exp_q[$];
    int                         ck_test_q[$];
    time                        rs_due_q[$];
    bp_types_pkg::lookup_resp_t rs_exp_q[$];
    int                         rs_test_q[$];

    int cur_test;
    int checks[5];
    int errors[5];

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock_gen (.clk(clk), .rst(rst));

    bp_history_top #(
        .HIST_LEN (bp_cfg_pkg::DEF_HIST_LEN)
    ) u_bp_history_top (
        .clk         (clk),
        .rst         (rst),
        .pred        (pred),
        .s2_redirect (s2_redirect),
        .squash      (squash),
        .sq_info     (sq_info),
        .lookup      (lookup),
        .history     (history),
        .resp        (resp)
    );

    function automatic string test_name(input int t);
        case (t)
            0: return "reset";
            1: return "random_predict";
            2: return "s2_redirect";
            3: return "squash_priority";
            default: return "lookup_hash";
        endcase
    endfunction

    // Fold bit p collects every bit of age below len with age mod w equal to p
    function automatic logic [7:0] fold_by_age(input int len, input int w);
        logic [7:0] f;
        int         pos;
        f = '0;
        for (int a = 0; a < len; a++) begin
            pos = (m_pos + 2 * bp_cfg_pkg::GHIST_SIZE - 1 - a) % bp_cfg_pkg::GHIST_SIZE;
            f[a % w] = f[a % w] ^ m_hist[pos];
        end
        return f;
    endfunction

    function automatic bp_types_pkg::hist_ckpt_t model_ckpt();
        bp_types_pkg::hist_ckpt_t c;
        logic [7:0]               t2;
        int                       len;
        c.ghist_idx = bp_cfg_pkg::GHIST_W'(m_pos);
        for (int b = 0; b < bp_cfg_pkg::TAGE_BANK; b++) begin
            len = int'(bp_cfg_pkg::DEF_HIST_LEN[b]);
            c.fold.idx[b] = fold_by_age(len, bp_cfg_pkg::IDX_W);
            c.fold.tag1[b] = fold_by_age(len, bp_cfg_pkg::TAG1_W);
            t2 = fold_by_age(len, bp_cfg_pkg::TAG2_W);
            c.fold.tag2[b] = t2[bp_cfg_pkg::TAG2_W-1:0];
        end
        return c;
    endfunction

    function automatic bp_types_pkg::lookup_resp_t hash_ref(input logic [31:0] pc,
                                                            input bp_types_pkg::tage_fold_t f);
        bp_types_pkg::lookup_resp_t r;
        logic [bp_cfg_pkg::PC_W-1:0] sh;
        r.valid = 1'b1;
        for (int b = 0; b < bp_cfg_pkg::TAGE_BANK; b++) begin
            sh = pc >> (2 + b);
            r.idx[b] = pc[bp_cfg_pkg::IDX_W+1:2] ^ f.idx[b] ^ sh[bp_cfg_pkg::IDX_W-1:0];
            r.tag[b] = pc[bp_cfg_pkg::TAG_W+1:2] ^ f.tag1[b] ^ {f.tag2[b], 1'b0};
        end
        return r;
    endfunction

    // Only the last appended outcome carries the taken flag
    task automatic append(input logic [1:0] n, input logic taken);
        for (int i = 0; i < int'(n); i++) begin
            m_hist[m_pos] = (i == int'(n) - 1) ? taken : 1'b0;
            m_pos = (m_pos + 1) % bp_cfg_pkg::GHIST_SIZE;
        end
    endtask

    function automatic bp_types_pkg::pred_event_t rand_pred();
        bp_types_pkg::pred_event_t p;
        p = '0;
        p.en = ($urandom_range(7, 0) != 0);  // Occasional idle cycle
        p.cond_num = 2'($urandom_range(2, 0));
        p.taken = 1'($urandom);
        return p;
    endfunction

    task automatic check_ckpt(input int t, input bp_types_pkg::hist_ckpt_t exp,
                              input bp_types_pkg::hist_ckpt_t act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            $display("** Error %s: history expected %h actual %h", test_name(t), exp, act);
        end
    endtask

    task automatic check_resp(input int t, input bp_types_pkg::lookup_resp_t exp,
                              input bp_types_pkg::lookup_resp_t act);
        checks[t]++;
        if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
            errors[t]++;
            $display("** Error %s: resp expected %h actual %h", test_name(t), exp, act);
        end
    endtask

    task automatic drive_cycle(input bp_types_pkg::pred_event_t p, input logic redir,
                               input logic sq, input bp_types_pkg::squash_event_t s,
                               input bp_types_pkg::lookup_req_t lk);
        bp_types_pkg::hist_ckpt_t   now;
        bp_types_pkg::lookup_resp_t exp_r;
        pred = p;
        s2_redirect = redir;
        squash = sq;
        sq_info = s;
        lookup = lk;
        now = model_ckpt();  // Hash sees the history from before this event
        if (lk.en) begin
            exp_r = hash_ref(lk.pc, now.fold);
        end else begin
            exp_r = '0;
        end
        if (sq) begin
            m_pos = int'(s.ckpt.ghist_idx);
            append(s.cond_num, s.taken);
        end else if (redir) begin
            m_pos = int'(p.redirect.ghist_idx);
            append(p.cond_num, p.taken);
        end else if (p.en) begin
            append(p.cond_num, p.taken);
        end
        rs_due_q.push_back($time + CLK_PERIOD);
        rs_exp_q.push_back(exp_r);
        rs_test_q.push_back(cur_test);
        ck_due_q.push_back($time + CLK_PERIOD);
        ck_exp_q.push_back(model_ckpt());
        ck_test_q.push_back(cur_test);
        @(negedge clk);
    endtask

    // Four predictions, then a restore to a checkpoint 1 to 4 events back
    task automatic restore_round(input logic use_squash);
        bp_types_pkg::pred_event_t   p;
        bp_types_pkg::squash_event_t s;
        bp_types_pkg::lookup_req_t   lk;
        logic [127:0]                junk;
        int                          k;
        lk = '0;
        s = '0;
        for (int i = 0; i < 4; i++) begin
            drive_cycle(rand_pred(), 1'b0, 1'b0, s, lk);
            path_q.push_back(model_ckpt());
        end
        k = $urandom_range(4, 1);
        p = rand_pred();
        p.en = 1'b1;
        if (use_squash) begin
            junk = {$urandom, $urandom, $urandom, $urandom};
            p.redirect = junk[$bits(bp_types_pkg::hist_ckpt_t)-1:0];  // Must lose to squash
            s.cond_num = 2'($urandom_range(2, 0));
            s.taken = 1'($urandom);
            s.ckpt = path_q[path_q.size() - 1 - k];
        end else begin
            p.redirect = path_q[path_q.size() - 1 - k];
        end
        repeat (k) void'(path_q.pop_back());
        drive_cycle(p, 1'b1, use_squash, s, lk);
        path_q.push_back(model_ckpt());
    endtask

    task automatic finish_test(input int t);
        pred = '0;
        s2_redirect = 1'b0;
        squash = 1'b0;
        lookup = '0;
        while (ck_due_q.size() != 0 || rs_due_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Test %0d %-16s checks %0d errors %0d", t, test_name(t), checks[t], errors[t]);
    endtask

    always @(negedge clk) begin
        while (ck_due_q.size() != 0 && ck_due_q[0] == $time) begin
            void'(ck_due_q.pop_front());
            check_ckpt(ck_test_q.pop_front(), ck_exp_q.pop_front(), history);
        end
        while (rs_due_q.size() != 0 && rs_due_q[0] == $time) begin
            void'(rs_due_q.pop_front());
            check_resp(rs_test_q.pop_front(), rs_exp_q.pop_front(), resp);
        end
    end

    initial begin
        #((TOTAL_EVENTS + 50) * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        bp_types_pkg::pred_event_t   idle_pred;
        bp_types_pkg::squash_event_t no_sq;
        bp_types_pkg::lookup_req_t   lk;
        bp_types_pkg::lookup_resp_t  idle_resp;
        int                          total_checks;
        int                          total_errors;
        void'($urandom(32'h2de5_39aa));
        pred = '0;
        s2_redirect = 1'b0;
        squash = 1'b0;
        sq_info = '0;
        lookup = '0;
        m_hist = '0;
        m_pos = 0;
        idle_pred = '0;
        no_sq = '0;
        lk = '0;
        idle_resp = '0;
        total_checks = 0;
        total_errors = 0;
        @(negedge rst);

        cur_test = 0;
        check_ckpt(0, model_ckpt(), history);
        check_resp(0, idle_resp, resp);
        repeat (4) drive_cycle(idle_pred, 1'b0, 1'b0, no_sq, lk);
        finish_test(0);

        cur_test = 1;
        repeat (N_PRED) drive_cycle(rand_pred(), 1'b0, 1'b0, no_sq, lk);
        finish_test(1);

        for (int t = 2; t <= 3; t++) begin
            cur_test = t;
            path_q.delete();
            path_q.push_back(model_ckpt());
            repeat (N_ROUND) restore_round(t == 3);
            finish_test(t);
        end

        cur_test = 4;
        for (int i = 0; i < N_LOOKUP; i++) begin
            lk.en = 1'b1;
            lk.pc = $urandom;
            drive_cycle(rand_pred(), 1'b0, 1'b0, no_sq, lk);
        end
        lk = '0;
        drive_cycle(idle_pred, 1'b0, 1'b0, no_sq, lk);  // Valid must drop again
        finish_test(4);

        for (int t = 0; t < 5; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Summary: 5 tests, %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // Release away from the sampling edge
        rst = 1'b0;
    end

endmodule
